// File: common/xm_req_if.sv
// one sel/ack memory request port
// requester holds sel, wr, addr and wdata until ack, drops sel after it
// ack is a single cycle pulse, read data valid with ack
`timescale 1ns/1ps

interface xm_req_if import xv_bus_pkg::*; ();
    logic   sel;        // request active
    logic   ack;        // one cycle completion
    logic   wr;         // 1 = write
    addr_t  addr;
    word_t  wdata;
    word_t  rdata;      // valid in ack cycle

    modport requester(output sel, wr, addr, wdata, input ack, rdata);
    modport responder(input sel, wr, addr, wdata, output ack, rdata);
endinterface

// File: common/xosera_config.svh
// build constants for the display controller
// sync timing is a tiny test mode, so a frame is short in simulation
// syncs are active high, counts are in pixels and lines
`ifndef XOSERA_CONFIG_SVH
`define XOSERA_CONFIG_SVH

`define VID_H_VISIBLE   32      // visible pixels per line
`define VID_H_FRONT     4
`define VID_H_SYNC      4
`define VID_H_BACK      4
`define VID_V_VISIBLE   8       // visible lines per frame
`define VID_V_FRONT     1
`define VID_V_SYNC      2
`define VID_V_BACK      1

`define VRAM_AW         12      // VRAM words = 2**VRAM_AW
`define COLOR_AW        8       // color memory entries = 2**COLOR_AW

`define VID_PIPE_DELAY  4       // scan counters to output pins
`define BUS_SYNC_STAGES 2       // host cs_n synchronizer, at least 2

`endif

// File: common/xv_bus_pkg.sv
// host side types: data words, register numbers, XR map and interrupt bits
// register numbers 9 to 15 are not decoded and read zero
package xv_bus_pkg;

    typedef logic [15:0] word_t;        // VRAM/XR data word
    typedef logic [15:0] addr_t;        // VRAM or XR word address

    // host register numbers, order is the bus encoding
    typedef enum logic [3:0] {
        XM_SYS_CTRL,                    // ro: [15] v_blank, [14] h_blank
        XM_INT_CTRL,                    // even: mask, odd: status/clear
        XM_XR_ADDR,
        XM_XR_DATA,
        XM_RD_INCR,
        XM_RD_ADDR,
        XM_WR_INCR,
        XM_WR_ADDR,
        XM_DATA
    } xm_reg_t;

    // XR address map
    localparam addr_t XR_COLOR_BASE  = 16'h8000;    // color memory region
    localparam addr_t XR_VID_CTRL    = 16'h0000;    // [15:8] border, [0] 4bpp
    localparam addr_t XR_VID_FB_ADDR = 16'h0001;    // frame buffer start
    localparam addr_t XR_VID_INTR    = 16'h0002;    // write raises soft intr

    typedef logic [1:0] intr_t;
    localparam int INTR_VBLANK = 0;
    localparam int INTR_SOFT   = 1;

endpackage

// File: common/xv_video_pkg.sv
// video side types: color index, color entry and the decoded pixel word
// leftmost pixel is always the most significant field of a word
package xv_video_pkg;

    typedef logic [7:0] color_idx_t;

    // color memory entry, alpha kept but not displayed
    typedef struct packed {
        logic [3:0] a;
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } argb_t;

    // one VRAM word seen as 8bpp or 4bpp indexes
    typedef union packed {
        logic [1:0][7:0] idx8;          // [1] is leftmost
        logic [3:0][3:0] idx4;          // [3] is leftmost
    } pixel_word_u;

endpackage

// File: hw/reg_interface/reg_interface.sv
// host register bus, 8 bits wide with byte select
// cs_n must stay low and high for at least 4 clocks, inputs stable while low
// host must leave one full cs cycle between accesses so requests finish
// odd byte writes act, even byte writes are latched for the next odd write
`timescale 1ns/1ps
`include "xosera_config.svh"

module reg_interface import xv_bus_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       bus_cs_n_i,         // strobe, active low
    input  wire logic       bus_rd_nwr_i,       // 1 = read
    input  wire xm_reg_t    bus_reg_num_i,
    input  wire logic       bus_bytesel_i,      // 1 = odd byte
    input  wire logic [7:0] bus_data_i,
    output logic      [7:0] bus_data_o,
    xm_req_if.requester     vram_o,
    xm_req_if.requester     xr_o,
    input  wire logic       h_blank_i,
    input  wire logic       v_blank_i,
    input  wire intr_t      intr_status_i,
    output intr_t           intr_mask_o,
    output intr_t           intr_clear_o        // one cycle clear strobe
);

logic [`BUS_SYNC_STAGES-1:0] cs_sync;   // msb is the synchronized cs_n
logic   cs_last;
logic   bus_strobe;                     // falling edge of synced cs_n
logic [7:0] even_byte;                  // latched high byte
addr_t  rd_addr;
addr_t  rd_incr;
addr_t  wr_addr;
addr_t  wr_incr;
addr_t  xr_addr;
word_t  rd_data;                        // VRAM prefetch
word_t  xr_data;                        // XR prefetch
word_t  reg_word;                       // selected register for reads
word_t  bus_word;

assign bus_strobe = cs_last & ~cs_sync[`BUS_SYNC_STAGES-1];
assign bus_word   = {even_byte, bus_data_i};

always_comb begin
    case (bus_reg_num_i)
        XM_SYS_CTRL:    reg_word = {v_blank_i, h_blank_i, 14'h0000};
        XM_INT_CTRL:    reg_word = {6'h00, intr_mask_o, 6'h00, intr_status_i};
        XM_XR_ADDR:     reg_word = xr_addr;
        XM_XR_DATA:     reg_word = xr_data;
        XM_RD_INCR:     reg_word = rd_incr;
        XM_RD_ADDR:     reg_word = rd_addr;
        XM_WR_INCR:     reg_word = wr_incr;
        XM_WR_ADDR:     reg_word = wr_addr;
        XM_DATA:        reg_word = rd_data;
        default:        reg_word = '0;
    endcase
end

// cs_n synchronizer, idles high
always_ff @(posedge clk) begin
    if (reset_i) begin
        cs_sync <= '1;
        cs_last <= 1'b1;
    end else begin
        cs_sync <= {cs_sync[`BUS_SYNC_STAGES-2:0], bus_cs_n_i};
        cs_last <= cs_sync[`BUS_SYNC_STAGES-1];
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        vram_o.sel   <= 1'b0;
        xr_o.sel     <= 1'b0;
        intr_mask_o  <= '0;
        intr_clear_o <= '0;
    end else begin
        intr_clear_o <= '0;

        // completions, increments wait for ack
        if (vram_o.ack) begin
            vram_o.sel <= 1'b0;
            if (vram_o.wr) begin
                wr_addr <= wr_addr + wr_incr;
            end else begin
                rd_data <= vram_o.rdata;
            end
        end
        if (xr_o.ack) begin
            xr_o.sel <= 1'b0;
            if (xr_o.wr) begin
                xr_addr <= xr_addr + 1'b1;
            end else begin
                xr_data <= xr_o.rdata;
            end
        end

        if (bus_strobe) begin
            if (bus_rd_nwr_i) begin
                bus_data_o <= bus_bytesel_i ? reg_word[7:0] : reg_word[15:8];   // held until next
                // odd data reads advance and prefetch again
                if (bus_bytesel_i && bus_reg_num_i == XM_DATA) begin
                    rd_addr     <= rd_addr + rd_incr;
                    vram_o.sel  <= 1'b1;
                    vram_o.wr   <= 1'b0;
                    vram_o.addr <= rd_addr + rd_incr;
                end
                if (bus_bytesel_i && bus_reg_num_i == XM_XR_DATA) begin
                    xr_addr   <= xr_addr + 1'b1;
                    xr_o.sel  <= 1'b1;
                    xr_o.wr   <= 1'b0;
                    xr_o.addr <= xr_addr + 1'b1;
                end
            end else if (!bus_bytesel_i) begin
                even_byte <= bus_data_i;
                if (bus_reg_num_i == XM_INT_CTRL) begin
                    intr_mask_o <= bus_data_i[1:0];
                end
            end else begin
                case (bus_reg_num_i)
                    XM_INT_CTRL:    intr_clear_o <= bus_data_i[1:0];   // write 1 to clear
                    XM_XR_ADDR: begin
                        xr_addr   <= bus_word;
                        xr_o.sel  <= 1'b1;          // prefetch
                        xr_o.wr   <= 1'b0;
                        xr_o.addr <= bus_word;
                    end
                    XM_XR_DATA: begin
                        xr_o.sel   <= 1'b1;
                        xr_o.wr    <= 1'b1;
                        xr_o.addr  <= xr_addr;
                        xr_o.wdata <= bus_word;
                    end
                    XM_RD_INCR:     rd_incr <= bus_word;
                    XM_RD_ADDR: begin
                        rd_addr     <= bus_word;
                        vram_o.sel  <= 1'b1;        // prefetch
                        vram_o.wr   <= 1'b0;
                        vram_o.addr <= bus_word;
                    end
                    XM_WR_INCR:     wr_incr <= bus_word;
                    XM_WR_ADDR:     wr_addr <= bus_word;
                    XM_DATA: begin
                        vram_o.sel   <= 1'b1;
                        vram_o.wr    <= 1'b1;
                        vram_o.addr  <= wr_addr;
                        vram_o.wdata <= bus_word;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end
end

endmodule

// File: hw/video_gen/video_gen.sv
// scan counters, video XR registers, frame buffer fetch and pixel output
// pipeline: counters, fetch, index select, color lookup, output register
// stage count is fixed at 4, VID_PIPE_DELAY must match
// fetch is at most every second cycle, VRAM read is one cycle registered
`timescale 1ns/1ps
`include "xosera_config.svh"

module video_gen import xv_bus_pkg::*, xv_video_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       xr_reg_wr_i,
    input  wire logic [1:0] xr_reg_num_i,
    input  wire word_t      xr_reg_data_i,
    output word_t           xr_reg_data_o,
    output logic            vram_sel_o,
    output addr_t           vram_addr_o,
    input  wire word_t      vram_data_i,
    output color_idx_t      color_idx_o,
    input  wire argb_t      color_i,
    output logic            h_blank_o,
    output logic            v_blank_o,
    output logic            vblank_intr_o,
    output logic            soft_intr_o,
    output logic      [3:0] red_o,
    output logic      [3:0] green_o,
    output logic      [3:0] blue_o,
    output logic            hsync_o,
    output logic            vsync_o,
    output logic            dv_de_o
);

localparam int H_TOTAL = `VID_H_VISIBLE + `VID_H_FRONT + `VID_H_SYNC + `VID_H_BACK;
localparam int V_TOTAL = `VID_V_VISIBLE + `VID_V_FRONT + `VID_V_SYNC + `VID_V_BACK;
localparam int H_SYNC_START = `VID_H_VISIBLE + `VID_H_FRONT;
localparam int V_SYNC_START = `VID_V_VISIBLE + `VID_V_FRONT;
localparam int PD = `VID_PIPE_DELAY - 1;    // flops before output register

logic [$clog2(H_TOTAL)-1:0] h_count;
logic [$clog2(V_TOTAL)-1:0] v_count;
logic           bpp4;                       // 0 = 8bpp
logic [7:0]     border_idx;                 // stored for readback
addr_t          fb_addr;
logic           de0;
logic           hs0;
logic           vs0;
logic [1:0]     sub0;                       // pixel within word
addr_t          pix_num;                    // pixel number in frame
logic [PD-1:0]  de_p;
logic [PD-1:0]  hs_p;
logic [PD-1:0]  vs_p;
logic [1:0]     sub1;
logic [1:0]     sub2;
word_t          word_q;                     // held fetch word
pixel_word_u    pix_word;

assign de0 = (h_count < `VID_H_VISIBLE) && (v_count < `VID_V_VISIBLE);
assign hs0 = (h_count >= H_SYNC_START) && (h_count < H_SYNC_START + `VID_H_SYNC);
assign vs0 = (v_count >= V_SYNC_START) && (v_count < V_SYNC_START + `VID_V_SYNC);
assign sub0 = bpp4 ? h_count[1:0] : {1'b0, h_count[0]};
assign pix_num = addr_t'(v_count * `VID_H_VISIBLE + h_count);
assign h_blank_o = (h_count >= `VID_H_VISIBLE);
assign v_blank_o = (v_count >= `VID_V_VISIBLE);

always_comb begin
    case (xr_reg_num_i)
        XR_VID_CTRL[1:0]:       xr_reg_data_o = {border_idx, 7'h00, bpp4};
        XR_VID_FB_ADDR[1:0]:    xr_reg_data_o = fb_addr;
        default:                xr_reg_data_o = '0;     // intr reg is write only
    endcase
end

// word arrives on first pixel of a group, later pixels use held copy
always_comb begin
    pix_word = (sub2 == 2'b00) ? vram_data_i : word_q;
    if (bpp4) begin
        color_idx_o = {4'h0, pix_word.idx4[~sub2]};
    end else begin
        color_idx_o = pix_word.idx8[~sub2[0]];
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count       <= '0;
        v_count       <= '0;
        bpp4          <= 1'b0;
        border_idx    <= '0;
        fb_addr       <= '0;
        vram_sel_o    <= 1'b0;
        vblank_intr_o <= 1'b0;
        soft_intr_o   <= 1'b0;
        de_p          <= '0;
        hs_p          <= '0;
        vs_p          <= '0;
        dv_de_o       <= 1'b0;
        hsync_o       <= 1'b0;
        vsync_o       <= 1'b0;
        {red_o, green_o, blue_o} <= '0;
    end else begin
        if (h_count == H_TOTAL - 1) begin
            h_count <= '0;
            v_count <= (v_count == V_TOTAL - 1) ? '0 : v_count + 1'b1;
        end else begin
            h_count <= h_count + 1'b1;
        end

        // XR video registers
        if (xr_reg_wr_i && xr_reg_num_i == XR_VID_CTRL[1:0]) begin
            bpp4       <= xr_reg_data_i[0];
            border_idx <= xr_reg_data_i[15:8];
        end
        if (xr_reg_wr_i && xr_reg_num_i == XR_VID_FB_ADDR[1:0]) begin
            fb_addr <= xr_reg_data_i;
        end
        soft_intr_o   <= xr_reg_wr_i && xr_reg_num_i == XR_VID_INTR[1:0];
        vblank_intr_o <= (h_count == 0) && (v_count == `VID_V_VISIBLE);   // first blank line

        vram_sel_o <= de0 && sub0 == 2'b00;     // once per word

        de_p <= {de_p[PD-2:0], de0};
        hs_p <= {hs_p[PD-2:0], hs0};
        vs_p <= {vs_p[PD-2:0], vs0};
        dv_de_o <= de_p[PD-1];
        hsync_o <= hs_p[PD-1];
        vsync_o <= vs_p[PD-1];
        {red_o, green_o, blue_o} <= de_p[PD-1] ? {color_i.r, color_i.g, color_i.b} : 12'h000;
    end
end

always_ff @(posedge clk) begin
    vram_addr_o <= fb_addr + (bpp4 ? pix_num >> 2 : pix_num >> 1);
    sub1 <= sub0;
    sub2 <= sub1;
    if (sub2 == 2'b00) begin
        word_q <= vram_data_i;
    end
end

endmodule

// File: hw/vram_arb.sv
// VRAM array with video priority grant
// video never waits, host waits while video selects
// host ack is one cycle after grant, read data comes with ack
`timescale 1ns/1ps
`include "xosera_config.svh"

module vram_arb import xv_bus_pkg::*; (
    input  wire logic   clk,
    input  wire logic   vgen_sel_i,         // video fetch, always wins
    input  wire addr_t  vgen_addr_i,
    xm_req_if.responder regs_i,
    output word_t       vram_data_o         // shared read data
);

word_t                  vram [0:2**`VRAM_AW-1];
logic                   regs_grant;
logic                   regs_ack;
logic [`VRAM_AW-1:0]    mem_addr;

assign regs_grant = regs_i.sel & ~vgen_sel_i & ~regs_ack;  // no regrant in ack cycle
assign mem_addr   = vgen_sel_i ? vgen_addr_i[`VRAM_AW-1:0] : regs_i.addr[`VRAM_AW-1:0];

assign regs_i.ack   = regs_ack;
assign regs_i.rdata = vram_data_o;

always_ff @(posedge clk) begin
    regs_ack <= regs_grant;
    if (regs_grant && regs_i.wr) begin
        vram[mem_addr] <= regs_i.wdata;
    end
    vram_data_o <= vram[mem_addr];      // read old data on write
end

endmodule

// File: hw/xosera_main.sv
// display controller top: host registers, video generator, VRAM and XR
// bus_intr_o pulses once when an enabled trigger is not already pending
// status bits stay set until the host clears them
`timescale 1ns/1ps

module xosera_main import xv_bus_pkg::*, xv_video_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       bus_cs_n_i,
    input  wire logic       bus_rd_nwr_i,       // 1 = read
    input  wire logic [3:0] bus_reg_num_i,
    input  wire logic       bus_bytesel_i,      // 1 = odd byte
    input  wire logic [7:0] bus_data_i,
    output logic      [7:0] bus_data_o,
    output logic            bus_intr_o,
    output logic      [3:0] red_o,
    output logic      [3:0] green_o,
    output logic      [3:0] blue_o,
    output logic            hsync_o,
    output logic            vsync_o,
    output logic            dv_de_o
);

logic       vgen_vram_sel;
addr_t      vgen_vram_addr;
word_t      vram_data;          // VRAM read data to video
color_idx_t color_idx;
argb_t      color_argb;
logic       xreg_wr;
logic [1:0] xreg_num;
word_t      xreg_wdata;
word_t      xreg_rdata;
logic       h_blank;
logic       v_blank;
intr_t      intr_trigger;
intr_t      intr_mask;
intr_t      intr_status;
intr_t      intr_clear;

xm_req_if vram_req();
xm_req_if xr_req();

reg_interface reg_interface_inst (
    .clk            (clk),
    .reset_i        (reset_i),
    .bus_cs_n_i     (bus_cs_n_i),
    .bus_rd_nwr_i   (bus_rd_nwr_i),
    .bus_reg_num_i  (xm_reg_t'(bus_reg_num_i)),
    .bus_bytesel_i  (bus_bytesel_i),
    .bus_data_i     (bus_data_i),
    .bus_data_o     (bus_data_o),
    .vram_o         (vram_req.requester),
    .xr_o           (xr_req.requester),
    .h_blank_i      (h_blank),
    .v_blank_i      (v_blank),
    .intr_status_i  (intr_status),
    .intr_mask_o    (intr_mask),
    .intr_clear_o   (intr_clear)
);

video_gen video_gen_inst (
    .clk            (clk),
    .reset_i        (reset_i),
    .xr_reg_wr_i    (xreg_wr),
    .xr_reg_num_i   (xreg_num),
    .xr_reg_data_i  (xreg_wdata),
    .xr_reg_data_o  (xreg_rdata),
    .vram_sel_o     (vgen_vram_sel),
    .vram_addr_o    (vgen_vram_addr),
    .vram_data_i    (vram_data),
    .color_idx_o    (color_idx),
    .color_i        (color_argb),
    .h_blank_o      (h_blank),
    .v_blank_o      (v_blank),
    .vblank_intr_o  (intr_trigger[INTR_VBLANK]),
    .soft_intr_o    (intr_trigger[INTR_SOFT]),
    .red_o          (red_o),
    .green_o        (green_o),
    .blue_o         (blue_o),
    .hsync_o        (hsync_o),
    .vsync_o        (vsync_o),
    .dv_de_o        (dv_de_o)
);

vram_arb vram_arb_inst (
    .clk            (clk),
    .vgen_sel_i     (vgen_vram_sel),
    .vgen_addr_i    (vgen_vram_addr),
    .regs_i         (vram_req.responder),
    .vram_data_o    (vram_data)
);

xrmem_arb xrmem_arb_inst (
    .clk            (clk),
    .regs_i         (xr_req.responder),
    .xreg_wr_o      (xreg_wr),
    .xreg_num_o     (xreg_num),
    .xreg_data_o    (xreg_wdata),
    .xreg_data_i    (xreg_rdata),
    .color_idx_i    (color_idx),
    .color_o        (color_argb)
);

// pending status and host interrupt strobe
always_ff @(posedge clk) begin
    if (reset_i) begin
        bus_intr_o  <= 1'b0;
        intr_status <= '0;
    end else begin
        bus_intr_o  <= |(intr_trigger & intr_mask & ~intr_status);    // new and enabled only
        intr_status <= (intr_status | intr_trigger) & ~intr_clear;
    end
end

endmodule

// File: hw/xrmem_arb.sv
// XR space decode: color memory above XR_COLOR_BASE, video registers below
// color memory is dual port, video lookup never stalls
// ack one cycle after sel, register reads use current video reg data
`timescale 1ns/1ps
`include "xosera_config.svh"

module xrmem_arb import xv_bus_pkg::*, xv_video_pkg::*; (
    input  wire logic       clk,
    xm_req_if.responder     regs_i,
    output logic            xreg_wr_o,
    output logic      [1:0] xreg_num_o,
    output word_t           xreg_data_o,
    input  wire word_t      xreg_data_i,
    input  wire color_idx_t color_idx_i,
    output argb_t           color_o
);

argb_t                  color_mem [0:2**`COLOR_AW-1];
logic                   is_color;
logic                   req;            // first cycle of a request
logic                   ack;
word_t                  rdata;
logic [`COLOR_AW-1:0]   color_addr;

assign is_color   = (regs_i.addr & XR_COLOR_BASE) != '0;
assign req        = regs_i.sel & ~ack;
assign color_addr = regs_i.addr[`COLOR_AW-1:0];

// video register bus
assign xreg_wr_o   = req & regs_i.wr & ~is_color;
assign xreg_num_o  = regs_i.addr[1:0];
assign xreg_data_o = regs_i.wdata;

assign regs_i.ack   = ack;
assign regs_i.rdata = rdata;

// host port
always_ff @(posedge clk) begin
    ack <= req;
    if (req && regs_i.wr && is_color) begin
        color_mem[color_addr] <= argb_t'(regs_i.wdata);
    end
    rdata <= is_color ? word_t'(color_mem[color_addr]) : xreg_data_i;
end

// video lookup port
always_ff @(posedge clk) begin
    color_o <= color_mem[color_idx_i];
end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it
# a failing simulation ends in $fatal and gives a nonzero exit status
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f xosera_main.f \
    --top-module tb_xosera_main -o tb_xosera_main
./obj_dir/tb_xosera_main

// File: verification/tb_xosera_tasks.svh
// testbench helpers for host bus access, random words, checks and the pixel model
// bus tasks start and return on a falling clock edge
// each access holds cs_n low 4 cycles and then high 4 cycles
`ifndef TB_XOSERA_TASKS_SVH
`define TB_XOSERA_TASKS_SVH

// 32 bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic word_t random_word();
    rng_state = xorshift32(rng_state);
    return rng_state[15:0];
endfunction

task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                        input string what);
    if (actual !== expected) begin
        $display("MISMATCH at time %0t: %s, got %0h expected %0h",
                 $time, what, actual, expected);
        stop_with_failure();
    end
endtask

// one strobe on the host bus, read data sampled just before cs_n rises
task automatic bus_access(input logic rd, input xm_reg_t reg_num, input logic odd,
                          input logic [7:0] wdata, output logic [7:0] rdata);
    bus_rd_nwr_i  = rd;
    bus_reg_num_i = reg_num;
    bus_bytesel_i = odd;
    bus_data_i    = wdata;
    bus_cs_n_i    = 1'b0;
    repeat (4) @(negedge clk);
    rdata      = bus_data_o;
    bus_cs_n_i = 1'b1;
    repeat (4) @(negedge clk);
    bus_accesses++;                     // widens the timeout
endtask

task automatic write_byte(input xm_reg_t reg_num, input logic odd, input logic [7:0] data);
    logic [7:0] unused;
    bus_access(1'b0, reg_num, odd, data, unused);
endtask

// even byte first, odd byte makes it take effect
task automatic write_reg(input xm_reg_t reg_num, input word_t data);
    write_byte(reg_num, 1'b0, data[15:8]);
    write_byte(reg_num, 1'b1, data[7:0]);
endtask

task automatic read_reg(input xm_reg_t reg_num, output word_t data);
    logic [7:0] hi;
    logic [7:0] lo;
    bus_access(1'b1, reg_num, 1'b0, 8'h00, hi);
    bus_access(1'b1, reg_num, 1'b1, 8'h00, lo);     // odd read may advance
    data = {hi, lo};
endtask

// expected 12 bit rgb of visible pixel (x, y) from the memory models
function automatic logic [11:0] ref_pixel(input int x, input int y);
    int         pix;
    int         waddr;
    word_t      w;
    logic [7:0] idx;
    argb_t      c;
    pix = y * `VID_H_VISIBLE + x;
    if (model_bpp4) begin
        waddr = (int'(model_fb_addr) + pix / 4) % VRAM_WORDS;
        w     = vram_model[waddr];
        idx   = {4'h0, w[15 - 4 * (x % 4) -: 4]};   // leftmost pixel in top nibble
    end else begin
        waddr = (int'(model_fb_addr) + pix / 2) % VRAM_WORDS;
        w     = vram_model[waddr];
        idx   = (x % 2 == 0) ? w[15:8] : w[7:0];
    end
    c = color_model[idx];
    return {c.r, c.g, c.b};
endfunction

`endif

// File: verification/tb_xosera_main.sv
// testbench for the display controller top level
// inputs change on the falling clock edge and outputs are sampled there too
// pixel checks cover whole frames only while the host bus is idle
// VRAM and color memory contents are modeled for the pixel reference
`timescale 1ns/1ps
`include "xosera_config.svh"

module tb_xosera_main import xv_bus_pkg::*, xv_video_pkg::*; ();

localparam int H_TOTAL = `VID_H_VISIBLE + `VID_H_FRONT + `VID_H_SYNC + `VID_H_BACK;
localparam int V_TOTAL = `VID_V_VISIBLE + `VID_V_FRONT + `VID_V_SYNC + `VID_V_BACK;
localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
localparam int FRAME_PIXELS = `VID_H_VISIBLE * `VID_V_VISIBLE;
localparam int VRAM_WORDS   = 2 ** `VRAM_AW;
localparam int COLORS       = 2 ** `COLOR_AW;
localparam addr_t FB_4BPP   = 16'h0400;     // second frame buffer

logic        clk;
logic        reset_i;
logic        bus_cs_n_i;
logic        bus_rd_nwr_i;
logic [3:0]  bus_reg_num_i;
logic        bus_bytesel_i;
logic [7:0]  bus_data_i;
logic [7:0]  bus_data_o;
logic        bus_intr_o;
logic [3:0]  red_o;
logic [3:0]  green_o;
logic [3:0]  blue_o;
logic        hsync_o;
logic        vsync_o;
logic        dv_de_o;
logic [11:0] rgb;

word_t       vram_model [0:VRAM_WORDS-1];
argb_t       color_model [0:COLORS-1];
logic        model_bpp4 = 1'b0;
addr_t       model_fb_addr = '0;
logic [31:0] rng_state = 32'd27;
int          bus_accesses = 0;
int          cycle_count = 0;
int          intr_pulses = 0;
logic        pixel_check_req = 1'b0;    // set by the test sequence
logic        check_en;                  // follows the request at frame start
int          pixels_checked = 0;
int          frames_seen = 0;
int          mon_x;
int          mon_y;
int          hs_len;
int          vs_len;
logic        de_q;
logic        hs_q;
logic        vs_q;

task automatic stop_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on the first error");
endtask

`include "tb_xosera_tasks.svh"

assign rgb = {red_o, green_o, blue_o};

xosera_main xosera_main_inst (
    .clk           (clk),
    .reset_i       (reset_i),
    .bus_cs_n_i    (bus_cs_n_i),
    .bus_rd_nwr_i  (bus_rd_nwr_i),
    .bus_reg_num_i (bus_reg_num_i),
    .bus_bytesel_i (bus_bytesel_i),
    .bus_data_i    (bus_data_i),
    .bus_data_o    (bus_data_o),
    .bus_intr_o    (bus_intr_o),
    .red_o         (red_o),
    .green_o       (green_o),
    .blue_o        (blue_o),
    .hsync_o       (hsync_o),
    .vsync_o       (vsync_o),
    .dv_de_o       (dv_de_o)
);

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;              // 8 ns period
end

// limit grows with every bus access issued
always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > 2 * (4 * FRAME_CYCLES + 64 * bus_accesses)) begin
        $display("timeout after %0d cycles, the test sequence did not finish", cycle_count);
        stop_with_failure();
    end
end

always @(negedge clk) begin
    if (!reset_i && bus_intr_o) begin
        intr_pulses++;                  // one count per high cycle
    end
end

// output monitor for pixel compare and frame timing
always @(negedge clk) begin
    if (reset_i !== 1'b0) begin
        mon_x    = 0;
        mon_y    = 0;
        hs_len   = 0;
        vs_len   = 0;
        de_q     = 1'b0;
        hs_q     = 1'b0;
        vs_q     = 1'b0;
        check_en = 1'b0;
    end else begin
        if (dv_de_o) begin
            if (check_en) begin
                check_eq(32'(rgb), 32'(ref_pixel(mon_x, mon_y)),
                         $sformatf("rgb at x %0d y %0d", mon_x, mon_y));
                pixels_checked++;
            end
            mon_x++;
        end else begin
            check_eq(32'(rgb), 32'd0, "rgb outside display enable");
            if (de_q) begin             // end of a visible line
                check_eq(mon_x, `VID_H_VISIBLE, "visible pixels per line");
                mon_x = 0;
                mon_y++;
            end
        end
        if (hsync_o) begin
            hs_len++;
        end else if (hs_q) begin
            check_eq(hs_len, `VID_H_SYNC, "hsync length in pixels");
            hs_len = 0;
        end
        if (vsync_o) begin
            vs_len++;
        end else if (vs_q) begin
            check_eq(vs_len, `VID_V_SYNC * H_TOTAL, "vsync length in cycles");
            vs_len = 0;
        end
        if (vsync_o && !vs_q) begin     // frame boundary
            check_eq(mon_y, `VID_V_VISIBLE, "visible lines per frame");
            mon_y    = 0;
            check_en = pixel_check_req;
            frames_seen++;
        end
        de_q = dv_de_o;
        hs_q = hsync_o;
        vs_q = vsync_o;
    end
end

task automatic wait_frames(input int n);
    int target;
    target = frames_seen + n;
    while (frames_seen < target) @(negedge clk);
endtask

// one whole frame compared against the model
task automatic check_frame();
    int target;
    target = pixels_checked + FRAME_PIXELS;
    pixel_check_req = 1'b1;
    while (pixels_checked < target) @(negedge clk);
    pixel_check_req = 1'b0;
    while (check_en) @(negedge clk);    // off again before host traffic
endtask

task automatic vram_fill(input addr_t start, input addr_t incr, input int count);
    word_t w;
    int    a;
    write_reg(XM_WR_INCR, incr);
    write_reg(XM_WR_ADDR, start);
    for (int i = 0; i < count; i++) begin
        w = random_word();
        a = (int'(start) + i * int'(incr)) % VRAM_WORDS;
        vram_model[a] = w;
        write_reg(XM_DATA, w);
    end
endtask

task automatic vram_verify(input addr_t start, input addr_t incr, input int count);
    logic [7:0] b;
    int         a;
    write_reg(XM_RD_INCR, incr);
    write_reg(XM_RD_ADDR, start);       // starts the prefetch
    for (int i = 0; i < count; i++) begin
        a = (int'(start) + i * int'(incr)) % VRAM_WORDS;
        bus_access(1'b1, XM_DATA, 1'b0, 8'h00, b);
        check_eq(32'(b), 32'(vram_model[a][15:8]), $sformatf("VRAM even byte at %0h", a));
        bus_access(1'b1, XM_DATA, 1'b1, 8'h00, b);
        check_eq(32'(b), 32'(vram_model[a][7:0]), $sformatf("VRAM odd byte at %0h", a));
    end
endtask

// mode, border and FB_ADDR written then read back
task automatic set_video(input logic bpp4, input addr_t fb);
    word_t w;
    word_t ctrl;
    ctrl = (random_word() & 16'hFF00) | word_t'(bpp4);     // random border index
    write_reg(XM_XR_ADDR, XR_VID_CTRL);
    write_reg(XM_XR_DATA, ctrl);
    write_reg(XM_XR_DATA, fb);          // XR address advanced to FB_ADDR
    model_bpp4    = bpp4;
    model_fb_addr = fb;
    write_reg(XM_XR_ADDR, XR_VID_CTRL);
    read_reg(XM_XR_DATA, w);
    check_eq(32'(w), 32'(ctrl), "VID_CTRL readback");
    read_reg(XM_XR_DATA, w);
    check_eq(32'(w), 32'(fb), "FB_ADDR readback");
endtask

task automatic soft_trigger();
    write_reg(XM_XR_ADDR, XR_VID_INTR);
    write_reg(XM_XR_DATA, 16'h0001);
    repeat (4) @(negedge clk);          // pulse is over by now
endtask

initial begin : test_sequence
    word_t w;
    word_t fb_rand;
    int    p0;
    bus_cs_n_i    = 1'b1;
    bus_rd_nwr_i  = 1'b1;
    bus_reg_num_i = 4'h0;
    bus_bytesel_i = 1'b0;
    bus_data_i    = 8'h00;
    reset_i       = 1'b1;
    repeat (8) @(negedge clk);
    reset_i = 1'b0;
    check_eq(32'(bus_intr_o), 32'd0, "bus_intr_o after reset");

    wait_frames(2);                     // monitor checks frame timing

    // VRAM round trip with increments 1 and 3
    vram_fill(16'h0200, 16'd1, 16);
    vram_fill(16'h0800, 16'd3, 16);
    vram_verify(16'h0200, 16'd1, 16);
    vram_verify(16'h0800, 16'd3, 16);

    // XR round trip over color memory then FB_ADDR
    write_reg(XM_XR_ADDR, XR_COLOR_BASE);
    for (int i = 0; i < COLORS; i++) begin
        color_model[i] = argb_t'(random_word());
        write_reg(XM_XR_DATA, word_t'(color_model[i]));
    end
    fb_rand = random_word();
    write_reg(XM_XR_ADDR, XR_VID_FB_ADDR);
    write_reg(XM_XR_DATA, fb_rand);
    write_reg(XM_XR_ADDR, XR_COLOR_BASE);
    for (int i = 0; i < COLORS; i++) begin
        read_reg(XM_XR_DATA, w);
        check_eq(32'(w), 32'(color_model[i]), $sformatf("color entry %0d", i));
    end
    write_reg(XM_XR_ADDR, XR_VID_FB_ADDR);
    read_reg(XM_XR_DATA, w);
    check_eq(32'(w), 32'(fb_rand), "random FB_ADDR readback");

    // 8bpp picture at word 0
    set_video(1'b0, 16'h0000);
    vram_fill(16'h0000, 16'd1, FRAME_PIXELS / 2);
    check_frame();

    // 4bpp picture at a nonzero start
    set_video(1'b1, FB_4BPP);
    vram_fill(FB_4BPP, 16'd1, FRAME_PIXELS / 4);
    check_frame();

    // interrupts with only the soft bit enabled
    write_byte(XM_INT_CTRL, 1'b0, 8'(1 << INTR_SOFT));
    write_byte(XM_INT_CTRL, 1'b1, 8'h03);
    p0 = intr_pulses;
    soft_trigger();
    check_eq(intr_pulses, p0 + 1, "pulses after soft trigger");
    read_reg(XM_INT_CTRL, w);
    check_eq(32'(w[9:8]), 32'(1 << INTR_SOFT), "interrupt mask readback");
    check_eq(32'(w[INTR_SOFT]), 32'd1, "soft status after trigger");
    soft_trigger();                     // still pending
    check_eq(intr_pulses, p0 + 1, "pulses after trigger while pending");
    write_byte(XM_INT_CTRL, 1'b1, 8'(1 << INTR_SOFT));
    read_reg(XM_INT_CTRL, w);
    check_eq(32'(w[INTR_SOFT]), 32'd0, "soft status after clear");
    write_byte(XM_INT_CTRL, 1'b1, 8'(1 << INTR_VBLANK));
    wait_frames(2);                     // at least one vblank start
    read_reg(XM_INT_CTRL, w);
    check_eq(32'(w[INTR_VBLANK]), 32'd1, "vblank status with mask clear");
    check_eq(intr_pulses, p0 + 1, "pulses after masked vblank");

    if (pixels_checked == 2 * FRAME_PIXELS) begin
        $display("*** TEST PASSED ***");
        $finish;
    end else begin
        $display("pixel monitor compared %0d pixels instead of %0d",
                 pixels_checked, 2 * FRAME_PIXELS);
        stop_with_failure();
    end
end

endmodule

// File: xosera_main.f
+incdir+common
+incdir+verification
common/xv_bus_pkg.sv
common/xv_video_pkg.sv
common/xm_req_if.sv
hw/reg_interface/reg_interface.sv
hw/video_gen/video_gen.sv
hw/vram_arb.sv
hw/xrmem_arb.sv
hw/xosera_main.sv
verification/tb_xosera_main.sv
